//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ecdsa_scalar
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hw/ecdsa_pkg.sv
hw/ecdsa_cmd_parser.sv
hw/mod_n_mult.sv
hw/mod_n_inv.sv
hw/sig_scalar_ctrl.sv
hw/reply_serializer.sv
hw/ecdsa_scalar_top.sv
sim/tb_ecdsa_scalar.sv

//--- hw/ecdsa_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module ecdsa_cmd_parser (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire ecdsa_pkg::stream_word_t i_cmd,
  input  wire logic                    i_cmd_val,
  output logic                         o_cmd_rdy,
  output ecdsa_pkg::sig_req_t          o_req,
  output logic                         o_req_val,
  input  wire logic                    i_req_rdy
);

  logic                   rdy_q;
  logic                   collecting;
  logic                   skipping;
  logic [3:0]             cnt;
  logic [3:0]             sel;
  logic                   take;
  ecdsa_pkg::cmd_header_t hdr;
  ecdsa_pkg::sig_req_t    req_q;

  assign hdr       = i_cmd.dat;
  assign o_cmd_rdy = rdy_q && !o_req_val;
  assign take      = i_cmd_val && o_cmd_rdy;
  // Word slot inside s, r or z
  assign sel       = cnt - 4'd2;
  assign o_req     = req_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rdy_q      <= 1'b0;
      collecting <= 1'b0;
      skipping   <= 1'b0;
      cnt        <= '0;
      o_req_val  <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
      if (o_req_val && i_req_rdy) begin
        o_req_val <= 1'b0;
      end
      if (take) begin
        if (collecting) begin
          cnt <= cnt + 4'd1;
          if (cnt == 4'(ecdsa_pkg::CMD_WORDS - 1)) begin
            collecting <= 1'b0;
            o_req_val  <= 1'b1;
          end
        end else if (skipping) begin
          if (i_cmd.eop) begin
            skipping <= 1'b0;
          end
        end else if (hdr.cmd == ecdsa_pkg::CMD_VERIFY_SIG) begin
          collecting <= 1'b1;
          cnt        <= 4'd1;
        end else if (!i_cmd.eop) begin
          // Unknown code, drop the rest of the command
          skipping <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (take && collecting) begin
      if (cnt == 4'd1) begin
        req_q.index <= i_cmd.dat;
      end else if (cnt < 2 + ecdsa_pkg::SCALAR_WORDS) begin
        req_q.s[sel[1:0]*ecdsa_pkg::WORD_BITS +: ecdsa_pkg::WORD_BITS] <= i_cmd.dat;
      end else if (cnt < 2 + 2 * ecdsa_pkg::SCALAR_WORDS) begin
        req_q.r[sel[1:0]*ecdsa_pkg::WORD_BITS +: ecdsa_pkg::WORD_BITS] <= i_cmd.dat;
      end else begin
        req_q.z[sel[1:0]*ecdsa_pkg::WORD_BITS +: ecdsa_pkg::WORD_BITS] <= i_cmd.dat;
      end
    end
  end

  // A new command must not start before the previous one ends
  a_no_sop_mid_cmd: assert property (@(posedge i_clk) disable iff (i_rst)
    (take && (collecting || skipping)) |-> !i_cmd.sop)
    else $error("sop received in the middle of a command");

endmodule

`default_nettype wire

//--- hw/ecdsa_pkg.sv
`default_nettype none

package ecdsa_pkg;

  localparam int WORD_BITS    = 64;
  localparam int SCALAR_BITS  = 256;
  localparam int SCALAR_WORDS = SCALAR_BITS / WORD_BITS;

  // Header, index, then s, r, z
  localparam int CMD_WORDS = 2 + 3 * SCALAR_WORDS;
  // Header, index, status, then u1, u2
  localparam int RPL_WORDS = 3 + 2 * SCALAR_WORDS;

  typedef logic [WORD_BITS-1:0]   word_t;
  typedef logic [SCALAR_BITS-1:0] scalar_t;

  // secp256k1 group order
  localparam scalar_t CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  localparam logic [15:0] CMD_VERIFY_SIG = 16'h0101;
  localparam logic [15:0] RPL_VERIFY_SIG = 16'h0201;

  typedef struct packed {
    word_t dat;
    logic  sop;
    logic  eop;
  } stream_word_t;

  // cmd sits in the low 16 bits of the word
  typedef struct packed {
    logic [31:0] rsvd;
    logic [15:0] len;
    logic [15:0] cmd;
  } cmd_header_t;

  typedef struct packed {
    word_t   index;
    scalar_t s;
    scalar_t r;
    scalar_t z;
  } sig_req_t;

  typedef struct packed {
    logic       s_out_of_range;
    logic       r_out_of_range;
    logic [5:0] rsvd;
  } sig_status_t;

  typedef struct packed {
    sig_status_t status;
    word_t       index;
    scalar_t     u1;
    scalar_t     u2;
  } sig_rpl_t;

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    INVERT,
    MULT_U1,
    MULT_U2,
    SEND
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/ecdsa_scalar_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecdsa_scalar_top (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire ecdsa_pkg::stream_word_t i_cmd,
  input  wire logic                    i_cmd_val,
  output logic                         o_cmd_rdy,
  output ecdsa_pkg::stream_word_t      o_rpl,
  output logic                         o_rpl_val,
  input  wire logic                    i_rpl_rdy
);

  ecdsa_pkg::sig_req_t req;
  logic                req_val;
  logic                req_rdy;
  ecdsa_pkg::scalar_t  inv_in;
  logic                inv_in_val;
  logic                inv_in_rdy;
  ecdsa_pkg::scalar_t  inv_out;
  logic                inv_out_val;
  logic                inv_out_rdy;
  ecdsa_pkg::scalar_t  mul_a;
  ecdsa_pkg::scalar_t  mul_b;
  logic                mul_in_val;
  logic                mul_in_rdy;
  ecdsa_pkg::scalar_t  mul_out;
  logic                mul_out_val;
  logic                mul_out_rdy;
  ecdsa_pkg::sig_rpl_t rpl;
  logic                rpl_val;
  logic                rpl_rdy;

  ecdsa_cmd_parser u_parser (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .i_cmd_val (i_cmd_val),
    .o_cmd_rdy (o_cmd_rdy),
    .o_req     (req),
    .o_req_val (req_val),
    .i_req_rdy (req_rdy)
  );

  sig_scalar_ctrl u_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_req         (req),
    .i_req_val     (req_val),
    .o_req_rdy     (req_rdy),
    .o_inv_in      (inv_in),
    .o_inv_in_val  (inv_in_val),
    .i_inv_in_rdy  (inv_in_rdy),
    .i_inv_out     (inv_out),
    .i_inv_out_val (inv_out_val),
    .o_inv_out_rdy (inv_out_rdy),
    .o_mul_a       (mul_a),
    .o_mul_b       (mul_b),
    .o_mul_in_val  (mul_in_val),
    .i_mul_in_rdy  (mul_in_rdy),
    .i_mul_out     (mul_out),
    .i_mul_out_val (mul_out_val),
    .o_mul_out_rdy (mul_out_rdy),
    .o_rpl         (rpl),
    .o_rpl_val     (rpl_val),
    .i_rpl_rdy     (rpl_rdy)
  );

  mod_n_inv u_inv (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (inv_in),
    .i_val (inv_in_val),
    .o_rdy (inv_in_rdy),
    .o_dat (inv_out),
    .o_val (inv_out_val),
    .i_rdy (inv_out_rdy)
  );

  mod_n_mult u_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (mul_a),
    .i_b   (mul_b),
    .i_val (mul_in_val),
    .o_rdy (mul_in_rdy),
    .o_p   (mul_out),
    .o_val (mul_out_val),
    .i_rdy (mul_out_rdy)
  );

  reply_serializer u_serializer (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_rpl     (rpl),
    .i_rpl_val (rpl_val),
    .o_rpl_rdy (rpl_rdy),
    .o_rpl     (o_rpl),
    .o_rpl_val (o_rpl_val),
    .i_rpl_rdy (i_rpl_rdy)
  );

endmodule

`default_nettype wire

//--- hw/mod_n_inv.sv
`timescale 1ns/1ps
`default_nettype none

module mod_n_inv (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire ecdsa_pkg::scalar_t i_dat,
  input  wire logic               i_val,
  output logic                    o_rdy,
  output ecdsa_pkg::scalar_t      o_dat,
  output logic                    o_val,
  input  wire logic               i_rdy
);

  localparam logic [ecdsa_pkg::SCALAR_BITS:0] N_EXT = {1'b0, ecdsa_pkg::CURVE_N};

  logic               busy;
  logic               done;
  ecdsa_pkg::scalar_t u;
  ecdsa_pkg::scalar_t v;
  ecdsa_pkg::scalar_t x1;
  ecdsa_pkg::scalar_t x2;
  ecdsa_pkg::scalar_t res;

  // x/2 mod n, adding n first when x is odd
  function automatic ecdsa_pkg::scalar_t half_mod(input ecdsa_pkg::scalar_t x);
    logic [ecdsa_pkg::SCALAR_BITS:0] t;
    t = x[0] ? {1'b0, x} + N_EXT : {1'b0, x};
    return t[ecdsa_pkg::SCALAR_BITS:1];
  endfunction

  // Wraps through 2^256 when a < b, which lands back in [0, n)
  function automatic ecdsa_pkg::scalar_t sub_mod(input ecdsa_pkg::scalar_t a,
                                                 input ecdsa_pkg::scalar_t b);
    return (a >= b) ? a - b : a - b + ecdsa_pkg::CURVE_N;
  endfunction

  assign o_rdy = !busy && !o_val;
  assign o_dat = res;
  assign done  = (u == ecdsa_pkg::scalar_t'(1)) || (v == ecdsa_pkg::scalar_t'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
    end else begin
      if (o_val && i_rdy) begin
        o_val <= 1'b0;
      end
      if (i_val && o_rdy) begin
        busy <= 1'b1;
      end else if (busy && done) begin
        busy  <= 1'b0;
        o_val <= 1'b1;
      end
    end
  end

  // Subtract and halve share a cycle so each step drops at least one bit
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      u  <= i_dat;
      v  <= ecdsa_pkg::CURVE_N;
      x1 <= ecdsa_pkg::scalar_t'(1);
      x2 <= '0;
    end else if (busy) begin
      if (u == ecdsa_pkg::scalar_t'(1)) begin
        res <= x1;
      end else if (v == ecdsa_pkg::scalar_t'(1)) begin
        res <= x2;
      end else if (!u[0]) begin
        u  <= u >> 1;
        x1 <= half_mod(x1);
      end else if (!v[0]) begin
        v  <= v >> 1;
        x2 <= half_mod(x2);
      end else if (u >= v) begin
        u  <= (u - v) >> 1;
        x1 <= half_mod(sub_mod(x1, x2));
      end else begin
        v  <= (v - u) >> 1;
        x2 <= half_mod(sub_mod(x2, x1));
      end
    end
  end

  a_nonzero_input: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |-> (i_dat != '0))
    else $error("inverter given a zero input");

endmodule

`default_nettype wire

//--- hw/mod_n_mult.sv
`timescale 1ns/1ps
`default_nettype none

module mod_n_mult (
  input  wire logic               i_clk,
  input  wire logic               i_rst,
  input  wire ecdsa_pkg::scalar_t i_a,
  input  wire ecdsa_pkg::scalar_t i_b,
  input  wire logic               i_val,
  output logic                    o_rdy,
  output ecdsa_pkg::scalar_t      o_p,
  output logic                    o_val,
  input  wire logic               i_rdy
);

  localparam logic [ecdsa_pkg::SCALAR_BITS:0] N_EXT = {1'b0, ecdsa_pkg::CURVE_N};

  logic                            busy;
  logic [7:0]                      step;
  ecdsa_pkg::scalar_t              a_q;
  ecdsa_pkg::scalar_t              b_q;
  ecdsa_pkg::scalar_t              acc;
  logic [ecdsa_pkg::SCALAR_BITS:0] dbl;
  logic [ecdsa_pkg::SCALAR_BITS:0] dbl_r;
  logic [ecdsa_pkg::SCALAR_BITS:0] sum;
  logic [ecdsa_pkg::SCALAR_BITS:0] sum_r;

  assign o_rdy = !busy && !o_val;
  assign o_p   = acc;

  // One double-and-add step, msb of b first
  always_comb begin
    dbl   = {acc, 1'b0};
    dbl_r = (dbl >= N_EXT) ? dbl - N_EXT : dbl;
    sum   = dbl_r + (b_q[ecdsa_pkg::SCALAR_BITS-1] ? {1'b0, a_q} : '0);
    sum_r = (sum >= N_EXT) ? sum - N_EXT : sum;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      step  <= '0;
      o_val <= 1'b0;
    end else begin
      if (o_val && i_rdy) begin
        o_val <= 1'b0;
      end
      if (i_val && o_rdy) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 8'd1;
        if (step == 8'd255) begin
          busy  <= 1'b0;
          o_val <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      a_q <= i_a;
      b_q <= i_b;
      acc <= '0;
    end else if (busy) begin
      acc <= sum_r[ecdsa_pkg::SCALAR_BITS-1:0];
      b_q <= b_q << 1;
    end
  end

  a_operands_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |-> (i_a < ecdsa_pkg::CURVE_N && i_b < ecdsa_pkg::CURVE_N))
    else $error("multiplier operand not reduced modulo n");

endmodule

`default_nettype wire

//--- hw/reply_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module reply_serializer (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire ecdsa_pkg::sig_rpl_t i_rpl,
  input  wire logic                i_rpl_val,
  output logic                     o_rpl_rdy,
  output ecdsa_pkg::stream_word_t  o_rpl,
  output logic                     o_rpl_val,
  input  wire logic                i_rpl_rdy
);

  logic                   busy;
  logic                   last;
  logic [3:0]             cnt;
  logic [3:0]             sel;
  ecdsa_pkg::sig_rpl_t    rpl_q;
  ecdsa_pkg::cmd_header_t hdr;

  assign o_rpl_rdy = !busy;
  assign o_rpl_val = busy;
  assign last      = (cnt == 4'(ecdsa_pkg::RPL_WORDS - 1));
  // Word slot inside u1 or u2
  assign sel       = cnt - 4'd3;

  always_comb begin
    hdr.rsvd = '0;
    hdr.len  = 16'(ecdsa_pkg::RPL_WORDS);
    hdr.cmd  = ecdsa_pkg::RPL_VERIFY_SIG;

    o_rpl.sop = (cnt == 4'd0);
    o_rpl.eop = last;
    if (cnt == 4'd0) begin
      o_rpl.dat = hdr;
    end else if (cnt == 4'd1) begin
      o_rpl.dat = rpl_q.index;
    end else if (cnt == 4'd2) begin
      o_rpl.dat = {{(ecdsa_pkg::WORD_BITS - 8){1'b0}}, rpl_q.status};
    end else if (cnt < 3 + ecdsa_pkg::SCALAR_WORDS) begin
      o_rpl.dat = rpl_q.u1[sel[1:0]*ecdsa_pkg::WORD_BITS +: ecdsa_pkg::WORD_BITS];
    end else begin
      o_rpl.dat = rpl_q.u2[sel[1:0]*ecdsa_pkg::WORD_BITS +: ecdsa_pkg::WORD_BITS];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else begin
      if (i_rpl_val && o_rpl_rdy) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy && i_rpl_rdy) begin
        if (last) begin
          busy <= 1'b0;
        end else begin
          cnt <= cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rpl_val && o_rpl_rdy) begin
      rpl_q <= i_rpl;
    end
  end

  a_hold_until_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rpl_val && !i_rpl_rdy) |=> (o_rpl_val && $stable(o_rpl)))
    else $error("reply word changed before it was accepted");

endmodule

`default_nettype wire

//--- hw/sig_scalar_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sig_scalar_ctrl (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire ecdsa_pkg::sig_req_t i_req,
  input  wire logic                i_req_val,
  output logic                     o_req_rdy,
  output ecdsa_pkg::scalar_t       o_inv_in,
  output logic                     o_inv_in_val,
  input  wire logic                i_inv_in_rdy,
  input  wire ecdsa_pkg::scalar_t  i_inv_out,
  input  wire logic                i_inv_out_val,
  output logic                     o_inv_out_rdy,
  output ecdsa_pkg::scalar_t       o_mul_a,
  output ecdsa_pkg::scalar_t       o_mul_b,
  output logic                     o_mul_in_val,
  input  wire logic                i_mul_in_rdy,
  input  wire ecdsa_pkg::scalar_t  i_mul_out,
  input  wire logic                i_mul_out_val,
  output logic                     o_mul_out_rdy,
  output ecdsa_pkg::sig_rpl_t      o_rpl,
  output logic                     o_rpl_val,
  input  wire logic                i_rpl_rdy
);

  ecdsa_pkg::ctrl_state_t state;
  ecdsa_pkg::sig_req_t    req_q;
  ecdsa_pkg::sig_rpl_t    rpl_q;
  ecdsa_pkg::scalar_t     w;
  logic                   s_bad;
  logic                   r_bad;
  logic                   inv_done;
  logic                   mul_done;

  assign s_bad = (req_q.s == '0) || (req_q.s >= ecdsa_pkg::CURVE_N);
  assign r_bad = (req_q.r == '0) || (req_q.r >= ecdsa_pkg::CURVE_N);

  assign o_req_rdy     = (state == ecdsa_pkg::IDLE);
  assign o_inv_in      = req_q.s;
  assign o_inv_out_rdy = (state == ecdsa_pkg::INVERT);
  // z*w first, then r*w
  assign o_mul_a       = (state == ecdsa_pkg::MULT_U2) ? req_q.r : req_q.z;
  assign o_mul_b       = w;
  assign o_mul_out_rdy = (state == ecdsa_pkg::MULT_U1) || (state == ecdsa_pkg::MULT_U2);
  assign o_rpl         = rpl_q;
  assign o_rpl_val     = (state == ecdsa_pkg::SEND);

  assign inv_done = i_inv_out_val && o_inv_out_rdy;
  assign mul_done = i_mul_out_val && o_mul_out_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= ecdsa_pkg::IDLE;
      o_inv_in_val <= 1'b0;
      o_mul_in_val <= 1'b0;
    end else begin
      if (o_inv_in_val && i_inv_in_rdy) begin
        o_inv_in_val <= 1'b0;
      end
      if (o_mul_in_val && i_mul_in_rdy) begin
        o_mul_in_val <= 1'b0;
      end
      case (state)
        ecdsa_pkg::IDLE: begin
          if (i_req_val) begin
            state <= ecdsa_pkg::CHECK;
          end
        end
        ecdsa_pkg::CHECK: begin
          if (s_bad || r_bad) begin
            state <= ecdsa_pkg::SEND;
          end else begin
            o_inv_in_val <= 1'b1;
            state        <= ecdsa_pkg::INVERT;
          end
        end
        ecdsa_pkg::INVERT: begin
          if (inv_done) begin
            o_mul_in_val <= 1'b1;
            state        <= ecdsa_pkg::MULT_U1;
          end
        end
        ecdsa_pkg::MULT_U1: begin
          if (mul_done) begin
            o_mul_in_val <= 1'b1;
            state        <= ecdsa_pkg::MULT_U2;
          end
        end
        ecdsa_pkg::MULT_U2: begin
          if (mul_done) begin
            state <= ecdsa_pkg::SEND;
          end
        end
        ecdsa_pkg::SEND: begin
          if (i_rpl_rdy) begin
            state <= ecdsa_pkg::IDLE;
          end
        end
        default: state <= ecdsa_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ecdsa_pkg::IDLE && i_req_val) begin
      req_q <= i_req;
    end
    if (state == ecdsa_pkg::CHECK) begin
      rpl_q.status.s_out_of_range <= s_bad;
      rpl_q.status.r_out_of_range <= r_bad;
      rpl_q.status.rsvd           <= '0;
      rpl_q.index                 <= req_q.index;
      rpl_q.u1                    <= '0;
      rpl_q.u2                    <= '0;
    end
    if (inv_done) begin
      w <= i_inv_out;
    end
    if (mul_done && state == ecdsa_pkg::MULT_U1) begin
      rpl_q.u1 <= i_mul_out;
    end
    if (mul_done && state == ecdsa_pkg::MULT_U2) begin
      rpl_q.u2 <= i_mul_out;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_ecdsa_scalar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecdsa_scalar;

  localparam time CLK_PERIOD = 8ns;
  localparam time DRIVE_DLY  = 1ns;
  localparam int  WAIT_LIMIT = 10000;
  localparam int  QUIET_CYCLES = 40;

  logic                    clk = 1'b0;
  logic                    rst;
  ecdsa_pkg::stream_word_t cmd;
  logic                    cmd_val;
  logic                    cmd_rdy;
  ecdsa_pkg::stream_word_t rpl;
  logic                    rpl_val;
  logic                    rpl_rdy;

  integer seed;
  int     checks;
  int     errors;
  int     timeouts;
  bit     aborted;
  int     next_index;

  ecdsa_scalar_top uut (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_cmd     (cmd),
    .i_cmd_val (cmd_val),
    .o_cmd_rdy (cmd_rdy),
    .o_rpl     (rpl),
    .o_rpl_val (rpl_val),
    .i_rpl_rdy (rpl_rdy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(input string name, input ecdsa_pkg::word_t exp,
                            input ecdsa_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_scalar(input string name, input ecdsa_pkg::scalar_t exp,
                              input ecdsa_pkg::scalar_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input ecdsa_pkg::sig_status_t exp,
                              input ecdsa_pkg::sig_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_framing(input string name, input logic exp_sop, input logic exp_eop,
                               input logic act_sop, input logic act_eop);
    checks++;
    if (act_sop !== exp_sop || act_eop !== exp_eop) begin
      errors++;
      $display("Error: %s sop/eop expected %h/%h got %h/%h",
               name, exp_sop, exp_eop, act_sop, act_eop);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %h got %h", name, exp, act);
    end
  endtask

  // Reference model, double-and-add modulo n
  task automatic ref_mul(input ecdsa_pkg::scalar_t a, input ecdsa_pkg::scalar_t b,
                         output ecdsa_pkg::scalar_t p);
    logic [256:0] acc;
    logic [256:0] n_ext;
    int           i;
    n_ext = {1'b0, ecdsa_pkg::CURVE_N};
    acc   = '0;
    for (i = 255; i >= 0; i--) begin
      acc = acc << 1;
      if (acc >= n_ext) acc = acc - n_ext;
      if (b[i]) begin
        acc = acc + {1'b0, a};
        if (acc >= n_ext) acc = acc - n_ext;
      end
    end
    p = acc[255:0];
  endtask

  // Inverse as s^(n-2) mod n
  task automatic ref_inv(input ecdsa_pkg::scalar_t s, output ecdsa_pkg::scalar_t w);
    ecdsa_pkg::scalar_t e;
    ecdsa_pkg::scalar_t res;
    int                 i;
    e   = ecdsa_pkg::CURVE_N - 256'd2;
    res = 256'd1;
    for (i = 255; i >= 0; i--) begin
      ref_mul(res, res, res);
      if (e[i]) ref_mul(res, s, res);
    end
    w = res;
  endtask

  // Range flags come from the test that chose the values
  task automatic build_expected(input ecdsa_pkg::sig_req_t req, input logic s_bad,
                                input logic r_bad, output ecdsa_pkg::sig_rpl_t exp);
    ecdsa_pkg::scalar_t w;
    exp.status.s_out_of_range = s_bad;
    exp.status.r_out_of_range = r_bad;
    exp.status.rsvd           = '0;
    exp.index                 = req.index;
    exp.u1                    = '0;
    exp.u2                    = '0;
    if (!s_bad && !r_bad) begin
      ref_inv(req.s, w);
      ref_mul(req.z, w, exp.u1);
      ref_mul(req.r, w, exp.u2);
    end
  endtask

  task automatic random_scalar(output ecdsa_pkg::scalar_t v);
    ecdsa_pkg::scalar_t t;
    int                 k;
    bit                 ok;
    ok = 1'b0;
    t  = '0;
    while (!ok) begin
      for (k = 0; k < 8; k++) t[k*32 +: 32] = $random(seed);
      ok = (t != '0) && (t < ecdsa_pkg::CURVE_N);
    end
    v = t;
  endtask

  task automatic make_req(input ecdsa_pkg::scalar_t s, input ecdsa_pkg::scalar_t r,
                          input ecdsa_pkg::scalar_t z, output ecdsa_pkg::sig_req_t req);
    req.index = 64'hA5C3_0000_0000_0000 | 64'(next_index);
    req.s     = s;
    req.r     = r;
    req.z     = z;
    next_index++;
  endtask

  // Called at the drive point after a rising edge, returns at the next one
  task automatic drive_word(input ecdsa_pkg::word_t dat, input logic sop, input logic eop);
    int cycles;
    cmd.dat = dat;
    cmd.sop = sop;
    cmd.eop = eop;
    cmd_val = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!cmd_rdy && !aborted) begin
      cycles++;
      if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: command word not accepted within %0d cycles", cycles);
        timeouts++;
        aborted = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    cmd_val = 1'b0;
  endtask

  task automatic send_verify(input ecdsa_pkg::sig_req_t req);
    ecdsa_pkg::cmd_header_t hdr;
    int                     k;
    hdr.rsvd = '0;
    hdr.len  = 16'(ecdsa_pkg::CMD_WORDS);
    hdr.cmd  = ecdsa_pkg::CMD_VERIFY_SIG;
    drive_word(hdr, 1'b1, 1'b0);
    drive_word(req.index, 1'b0, 1'b0);
    for (k = 0; k < 4; k++) drive_word(req.s[k*64 +: 64], 1'b0, 1'b0);
    for (k = 0; k < 4; k++) drive_word(req.r[k*64 +: 64], 1'b0, 1'b0);
    for (k = 0; k < 4; k++) drive_word(req.z[k*64 +: 64], 1'b0, k == 3);
  endtask

  task automatic send_unknown(input logic [15:0] code, input int words);
    ecdsa_pkg::cmd_header_t hdr;
    int                     k;
    hdr.rsvd = '0;
    hdr.len  = 16'(words);
    hdr.cmd  = code;
    drive_word(hdr, 1'b1, 1'b0);
    for (k = 1; k < words; k++) drive_word(64'hDEAD_0000_0000_0000 | 64'(k), 1'b0, k == words - 1);
  endtask

  task automatic receive_reply(input ecdsa_pkg::sig_rpl_t exp, input bit random_rdy);
    ecdsa_pkg::word_t       words [ecdsa_pkg::RPL_WORDS];
    ecdsa_pkg::cmd_header_t hdr;
    ecdsa_pkg::scalar_t     u1;
    ecdsa_pkg::scalar_t     u2;
    int                     k;
    int                     cycles;
    int                     rnd;
    bit                     got;
    for (k = 0; k < ecdsa_pkg::RPL_WORDS && !aborted; k++) begin
      cycles = 0;
      got    = 1'b0;
      while (!got && !aborted) begin
        rnd     = $random(seed);
        rpl_rdy = random_rdy ? rnd[0] : 1'b1;
        @(negedge clk);
        if (rpl_val && rpl_rdy) begin
          got      = 1'b1;
          words[k] = rpl.dat;
          check_framing($sformatf("reply word %0d", k), k == 0,
                        k == ecdsa_pkg::RPL_WORDS - 1, rpl.sop, rpl.eop);
        end else begin
          cycles++;
          if (cycles >= WAIT_LIMIT) begin
            $display("Timeout: reply word %0d not received within %0d cycles", k, cycles);
            timeouts++;
            aborted = 1'b1;
          end
        end
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
    rpl_rdy = 1'b0;
    if (!aborted) begin
      hdr.rsvd = '0;
      hdr.len  = 16'(ecdsa_pkg::RPL_WORDS);
      hdr.cmd  = ecdsa_pkg::RPL_VERIFY_SIG;
      for (k = 0; k < 4; k++) begin
        u1[k*64 +: 64] = words[3 + k];
        u2[k*64 +: 64] = words[7 + k];
      end
      check_word("reply header", hdr, words[0]);
      check_word("reply index", exp.index, words[1]);
      check_status("reply status", exp.status, words[2][7:0]);
      check_word("status upper bits", '0, {8'h00, words[2][63:8]});
      check_scalar("u1", exp.u1, u1);
      check_scalar("u2", exp.u2, u2);
    end
  endtask

  task automatic expect_no_reply(input int cycles);
    int k;
    for (k = 0; k < cycles; k++) begin
      @(negedge clk);
      if (rpl_val) begin
        errors++;
        $display("Unexpected reply word appeared after the last expected reply");
        break;
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic run_single(input ecdsa_pkg::sig_req_t req, input logic s_bad,
                            input logic r_bad, input bit random_rdy);
    ecdsa_pkg::sig_rpl_t exp;
    build_expected(req, s_bad, r_bad, exp);
    send_verify(req);
    receive_reply(exp, random_rdy);
  endtask

  task automatic test_valid();
    ecdsa_pkg::sig_req_t req;
    ecdsa_pkg::scalar_t  s;
    ecdsa_pkg::scalar_t  r;
    ecdsa_pkg::scalar_t  z;
    int                  k;
    $display("Test: valid signatures");
    make_req(256'h3F1E_92C4_7A05_D6B8_11E2_C0DE_4477_9A3B_5C6D_8E9F_0A1B_2C3D_4E5F_6071_8293_A4B5,
             256'h7B2D_0E4F_6A81_93C5_D7E9_FB0D_1F23_3547_5967_7B8D_9FA1_B3C5_D7E9_FB0D_1F23_3547,
             256'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210_0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0,
             req);
    run_single(req, 1'b0, 1'b0, 1'b0);
    make_req(ecdsa_pkg::CURVE_N - 256'd1, 256'd1, ecdsa_pkg::CURVE_N - 256'd1, req);
    run_single(req, 1'b0, 1'b0, 1'b0);
    for (k = 0; k < 3 && !aborted; k++) begin
      random_scalar(s);
      random_scalar(r);
      random_scalar(z);
      make_req(s, r, z, req);
      run_single(req, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic test_range();
    ecdsa_pkg::sig_req_t req;
    $display("Test: s and r out of range");
    make_req('0, 256'h1234, 256'h5678, req);
    run_single(req, 1'b1, 1'b0, 1'b0);
    make_req(ecdsa_pkg::CURVE_N, 256'h1234, 256'h5678, req);
    run_single(req, 1'b1, 1'b0, 1'b0);
    make_req(256'h9ABC, '0, 256'h5678, req);
    run_single(req, 1'b0, 1'b1, 1'b0);
    make_req(256'h9ABC, '1, 256'h5678, req);
    run_single(req, 1'b0, 1'b1, 1'b0);
    make_req(ecdsa_pkg::CURVE_N, '0, 256'h5678, req);
    run_single(req, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic test_unknown_cmd();
    ecdsa_pkg::sig_req_t req;
    ecdsa_pkg::scalar_t  s;
    $display("Test: unknown command is skipped");
    random_scalar(s);
    make_req(s, 256'h2222, 256'h3333, req);
    send_unknown(16'h0777, 5);
    run_single(req, 1'b0, 1'b0, 1'b0);
    expect_no_reply(QUIET_CYCLES);
  endtask

  task automatic test_backpressure();
    ecdsa_pkg::sig_req_t req;
    ecdsa_pkg::scalar_t  s;
    ecdsa_pkg::scalar_t  r;
    ecdsa_pkg::scalar_t  z;
    int                  k;
    $display("Test: random reply back-pressure");
    for (k = 0; k < 3 && !aborted; k++) begin
      random_scalar(s);
      random_scalar(r);
      random_scalar(z);
      make_req(s, r, z, req);
      run_single(req, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic test_back_to_back();
    ecdsa_pkg::sig_req_t reqs [3];
    ecdsa_pkg::sig_rpl_t exps [3];
    ecdsa_pkg::scalar_t  s;
    ecdsa_pkg::scalar_t  r;
    ecdsa_pkg::scalar_t  z;
    int                  k;
    int                  ks;
    int                  kr;
    $display("Test: three commands back to back");
    for (k = 0; k < 3; k++) begin
      random_scalar(s);
      random_scalar(r);
      random_scalar(z);
      // Middle one fails the range check so the pipeline mixes both paths
      make_req(s, (k == 1) ? '0 : r, z, reqs[k]);
      build_expected(reqs[k], 1'b0, k == 1, exps[k]);
    end
    fork
      begin
        for (ks = 0; ks < 3; ks++) send_verify(reqs[ks]);
      end
      begin
        for (kr = 0; kr < 3; kr++) receive_reply(exps[kr], 1'b0);
      end
    join
  endtask

  initial begin
    seed       = 57;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    aborted    = 1'b0;
    next_index = 1;
    rst        = 1'b1;
    cmd        = '0;
    cmd_val    = 1'b0;
    rpl_rdy    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("o_cmd_rdy", 1'b0, cmd_rdy);
    check_flag("o_rpl_val", 1'b0, rpl_val);
    @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    // Ready comes up on the first edge that sees reset low
    @(posedge clk);
    @(negedge clk);
    check_flag("o_cmd_rdy", 1'b1, cmd_rdy);
    check_flag("o_rpl_val", 1'b0, rpl_val);
    @(posedge clk);
    #DRIVE_DLY;

    if (!aborted) test_valid();
    if (!aborted) test_range();
    if (!aborted) test_unknown_cmd();
    if (!aborted) test_backpressure();
    if (!aborted) test_back_to_back();

    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
